/* rtl/l1_rcache_config.svh */
`ifndef L1_RCACHE_CONFIG_SVH
`define L1_RCACHE_CONFIG_SVH

// Cache geometry, 2, 4 or 8 ways
`define L1_WAYS 4
`define L1_SETS 256

// Fill sequencing assumes a four word line
`define L1_WORDS_PER_LINE 4

// Bus widths
`define L1_ADDR_W 32
`define L1_DATA_W 32
`define L1_ID_W 4

// Derived address split
`define L1_INDEX_W ($clog2(`L1_SETS))
`define L1_WSEL_W ($clog2(`L1_WORDS_PER_LINE))
`define L1_TAG_W (`L1_ADDR_W - `L1_INDEX_W - `L1_WSEL_W - 2)
`define L1_LINE_W (`L1_WORDS_PER_LINE * `L1_DATA_W)

`endif

/* rtl/l1_rcache_pkg.sv */
`include "l1_rcache_config.svh"

package l1_rcache_pkg;

	// Read request from the core
	typedef struct packed {
		logic [`L1_ADDR_W-1:0] addr;
		logic [`L1_ID_W-1:0] id;
		logic cacheable;
	} rd_req_t;

	// Single word response back to the core
	typedef struct packed {
		logic [`L1_DATA_W-1:0] data;
		logic [`L1_ID_W-1:0] id;
		logic err;
	} rd_rsp_t;

	// Memory read request, wrap set means a four beat wrapping line fill
	typedef struct packed {
		logic [`L1_ADDR_W-1:0] addr;
		logic wrap;
	} mem_req_t;

	// One beat of memory read data
	typedef struct packed {
		logic [`L1_DATA_W-1:0] data;
		logic err;
		logic last;
	} mem_beat_t;

	// Tag array entry
	typedef struct packed {
		logic valid;
		logic [`L1_TAG_W-1:0] tag;
	} tag_entry_t;

	// Data array entry, word 0 at the low end
	typedef struct packed {
		logic [`L1_WORDS_PER_LINE-1:0][`L1_DATA_W-1:0] word;
	} line_t;

endpackage

/* rtl/cache_sram.sv */
`timescale 1ns/100ps
`include "l1_rcache_config.svh"

module cache_sram #(
	parameter type entry_t = logic [`L1_DATA_W-1:0],
	parameter int DEPTH = `L1_SETS,
	parameter bit ZERO_INIT = 1'b0
) (
	input  logic                     clk_i,
	input  logic                     rst_n,
	input  logic [$clog2(DEPTH)-1:0] i_addr,
	input  logic                     i_we,
	input  entry_t                   i_wdata,
	output entry_t                   o_rdata,
	output logic                     o_busy
);
	localparam int AW = $clog2(DEPTH);

	entry_t mem [DEPTH];
	logic [AW-1:0] sweep_addr;
	logic sweeping;

	// Walk every entry once after reset when clearing is enabled
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			sweeping <= ZERO_INIT;
			sweep_addr <= '0;
		end else if (sweeping) begin
			sweep_addr <= sweep_addr + 1'b1;
			if (sweep_addr == AW'(DEPTH - 1)) begin
				sweeping <= 1'b0;
			end
		end
	end

	// Registered read, read data shows the old entry on a write
	always_ff @(posedge clk_i) begin
		if (sweeping) begin
			mem[sweep_addr] <= '0;
		end else if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
		o_rdata <= mem[i_addr];
	end

	assign o_busy = sweeping;

	// The owner has to hold off writes until the clear is done
	a_no_write_in_sweep: assert property (@(posedge clk_i) disable iff (!rst_n)
		sweeping |-> !i_we);

endmodule

/* rtl/tag_lookup.sv */
`timescale 1ns/100ps
`include "l1_rcache_config.svh"

module tag_lookup (
	input  logic                        clk_i,
	input  logic                        rst_n,
	input  logic                        i_lookup,
	input  logic [`L1_ADDR_W-1:0]       i_addr,
	input  logic                        i_commit,
	input  logic [`L1_ADDR_W-1:0]       i_commit_addr,
	input  logic [`L1_ADDR_W-1:0]       i_snoop_addr,
	input  logic                        i_snoop_valid,
	input  logic                        i_idle,
	output logic                        o_hit,
	output logic [$clog2(`L1_WAYS)-1:0] o_hit_way,
	output logic [$clog2(`L1_WAYS)-1:0] o_victim_way,
	output logic                        o_busy
);
	localparam int WAY_W = $clog2(`L1_WAYS);
	localparam int IDX_LSB = `L1_WSEL_W + 2;
	localparam int TAG_LSB = IDX_LSB + `L1_INDEX_W;

	l1_rcache_pkg::tag_entry_t rdata [`L1_WAYS];
	l1_rcache_pkg::tag_entry_t wdata;
	logic [`L1_WAYS-1:0] way_we;
	logic [`L1_WAYS-1:0] way_match;
	logic [`L1_WAYS-1:0] sweep_busy;
	logic [`L1_INDEX_W-1:0] sram_addr;
	logic [`L1_INDEX_W-1:0] snoop_idx_q;
	logic [`L1_TAG_W-1:0] cmp_tag_q;
	logic [WAY_W-1:0] victim_q;
	logic snoop_take;
	logic snoop_pend;
	logic lookup_q;

	// Snoops are only taken while the controller sits idle
	assign snoop_take = i_snoop_valid && i_idle && !(|sweep_busy);

	// One shared index for all ways
	always_comb begin
		if (snoop_pend) begin
			sram_addr = snoop_idx_q;
		end else if (i_commit) begin
			sram_addr = i_commit_addr[TAG_LSB-1:IDX_LSB];
		end else if (snoop_take) begin
			sram_addr = i_snoop_addr[TAG_LSB-1:IDX_LSB];
		end else begin
			sram_addr = i_addr[TAG_LSB-1:IDX_LSB];
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			snoop_pend <= 1'b0;
			lookup_q <= 1'b0;
			victim_q <= '0;
		end else begin
			snoop_pend <= snoop_take;
			lookup_q <= i_lookup;
			// Round robin replacement
			if (i_commit) begin
				victim_q <= victim_q + 1'b1;
			end
		end
	end

	// Tag to compare against the set that comes out next cycle
	always_ff @(posedge clk_i) begin
		if (snoop_take) begin
			cmp_tag_q <= i_snoop_addr[`L1_ADDR_W-1:TAG_LSB];
			snoop_idx_q <= i_snoop_addr[TAG_LSB-1:IDX_LSB];
		end else if (i_lookup) begin
			cmp_tag_q <= i_addr[`L1_ADDR_W-1:TAG_LSB];
		end
	end

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < `L1_WAYS; w++) begin
			way_match[w] = rdata[w].valid && (rdata[w].tag == cmp_tag_q);
			if (way_match[w]) begin
				o_hit_way = WAY_W'(w);
			end
		end
	end

	// A snoop clear writes an invalid entry
	always_comb begin
		wdata.valid = !snoop_pend;
		wdata.tag = i_commit_addr[`L1_ADDR_W-1:TAG_LSB];
	end

	for (genvar w = 0; w < `L1_WAYS; w++) begin : g_way
		assign way_we[w] = snoop_pend ? way_match[w] : (i_commit && victim_q == WAY_W'(w));

		cache_sram #(
			.entry_t(l1_rcache_pkg::tag_entry_t),
			.DEPTH(`L1_SETS),
			.ZERO_INIT(1'b1)
		) u_tag (
			.clk_i(clk_i),
			.rst_n(rst_n),
			.i_addr(sram_addr),
			.i_we(way_we[w]),
			.i_wdata(wdata),
			.o_rdata(rdata[w]),
			.o_busy(sweep_busy[w])
		);
	end

	assign o_hit = lookup_q && (|way_match);
	assign o_victim_way = victim_q;
	assign o_busy = (|sweep_busy) || snoop_pend || snoop_take;

	// Fills always go to a missing line, so a tag lives in one way only
	a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_n)
		lookup_q |-> $onehot0(way_match));

endmodule

/* rtl/rcache_ctrl.sv */
`timescale 1ns/100ps
`include "l1_rcache_config.svh"

module rcache_ctrl (
	input  logic                        clk_i,
	input  logic                        rst_n,
	input  l1_rcache_pkg::rd_req_t      i_req,
	input  logic                        i_req_valid,
	output logic                        o_req_ready,
	output l1_rcache_pkg::rd_rsp_t      o_rsp,
	output logic                        o_rsp_valid,
	input  logic                        i_rsp_ready,
	output l1_rcache_pkg::mem_req_t     o_mem_req,
	output logic                        o_mem_req_valid,
	input  logic                        i_mem_req_ready,
	input  l1_rcache_pkg::mem_beat_t    i_mem_beat,
	input  logic                        i_mem_beat_valid,
	output logic                        o_mem_beat_ready,
	output logic                        o_lookup,
	output logic [`L1_ADDR_W-1:0]       o_lookup_addr,
	input  logic                        i_hit,
	input  logic [$clog2(`L1_WAYS)-1:0] i_hit_way,
	input  logic [$clog2(`L1_WAYS)-1:0] i_victim_way,
	output logic                        o_commit,
	output logic [`L1_ADDR_W-1:0]       o_commit_addr,
	output logic                        o_idle,
	input  logic                        i_tag_busy
);
	localparam int WAY_W = $clog2(`L1_WAYS);
	localparam int IDX_LSB = `L1_WSEL_W + 2;
	localparam int TAG_LSB = IDX_LSB + `L1_INDEX_W;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_HIT_RSP,
		ST_FILL_REQ,
		ST_FILL_FIRST,
		ST_FILL_STALL,
		ST_FILL_REST,
		ST_UNC_REQ,
		ST_UNC_DATA
	} state_e;

	state_e state;
	l1_rcache_pkg::rd_req_t req_q;
	l1_rcache_pkg::rd_rsp_t rsp_hold_q;
	l1_rcache_pkg::line_t fill_line_q;
	l1_rcache_pkg::line_t fill_line;
	l1_rcache_pkg::line_t line_rdata [`L1_WAYS];
	logic [WAY_W-1:0] hit_way_q;
	logic [`L1_WSEL_W-1:0] req_wsel;
	logic [`L1_WSEL_W-1:0] fill_pos;
	logic [`L1_WSEL_W-1:0] beat_cnt;
	logic lookup_phase;
	logic fill_err_q;
	logic req_fire;
	logic rsp_fire;
	logic mreq_fire;
	logic beat_fire;
	logic fill_beat;
	logic fill_done;
	logic line_wr;

	assign req_wsel = req_q.addr[IDX_LSB-1:2];
	assign o_idle = (state == ST_IDLE);
	assign o_req_ready = o_idle && !i_tag_busy;

	assign req_fire = i_req_valid && o_req_ready;
	assign rsp_fire = o_rsp_valid && i_rsp_ready;
	assign mreq_fire = o_mem_req_valid && i_mem_req_ready;
	assign beat_fire = i_mem_beat_valid && o_mem_beat_ready;
	assign fill_beat = beat_fire && (state == ST_FILL_FIRST || state == ST_FILL_REST);
	assign fill_done = beat_fire && state == ST_FILL_REST &&
		beat_cnt == `L1_WSEL_W'(`L1_WORDS_PER_LINE - 1);

	// A line with a bad beat is handed out but never kept
	assign line_wr = fill_done && !fill_err_q && !i_mem_beat.err;

	assign o_lookup = (state == ST_LOOKUP) && !lookup_phase;
	assign o_lookup_addr = req_q.addr;
	assign o_commit = line_wr;
	assign o_commit_addr = req_q.addr;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			lookup_phase <= 1'b0;
			beat_cnt <= '0;
			fill_err_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_fire) begin
						lookup_phase <= 1'b0;
						state <= i_req.cacheable ? ST_LOOKUP : ST_UNC_REQ;
					end
				end
				// First cycle reads the tags, second one sees the compare
				ST_LOOKUP: begin
					lookup_phase <= 1'b1;
					if (lookup_phase) begin
						state <= i_hit ? ST_HIT_RSP : ST_FILL_REQ;
					end
				end
				ST_HIT_RSP: begin
					if (rsp_fire) begin
						state <= ST_IDLE;
					end
				end
				ST_FILL_REQ: begin
					if (mreq_fire) begin
						beat_cnt <= '0;
						fill_err_q <= 1'b0;
						state <= ST_FILL_FIRST;
					end
				end
				ST_FILL_FIRST: begin
					if (beat_fire) begin
						beat_cnt <= beat_cnt + 1'b1;
						fill_err_q <= i_mem_beat.err;
						state <= i_rsp_ready ? ST_FILL_REST : ST_FILL_STALL;
					end
				end
				// Core has not taken the critical word yet
				ST_FILL_STALL: begin
					if (rsp_fire) begin
						state <= ST_FILL_REST;
					end
				end
				ST_FILL_REST: begin
					if (beat_fire) begin
						beat_cnt <= beat_cnt + 1'b1;
						fill_err_q <= fill_err_q || i_mem_beat.err;
						if (fill_done) begin
							state <= ST_IDLE;
						end
					end
				end
				ST_UNC_REQ: begin
					if (mreq_fire) begin
						state <= ST_UNC_DATA;
					end
				end
				ST_UNC_DATA: begin
					if (rsp_fire) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_fire) begin
			req_q <= i_req;
		end
		if (state == ST_LOOKUP && lookup_phase) begin
			hit_way_q <= i_hit_way;
		end
		// Wrapping fill starts at the requested word
		if (mreq_fire) begin
			fill_pos <= req_wsel;
		end else if (fill_beat) begin
			fill_line_q.word[fill_pos] <= i_mem_beat.data;
			fill_pos <= fill_pos + 1'b1;
		end
		if (state == ST_FILL_FIRST && beat_fire) begin
			rsp_hold_q.data <= i_mem_beat.data;
			rsp_hold_q.id <= req_q.id;
			rsp_hold_q.err <= i_mem_beat.err;
		end
	end

	// Last beat goes straight into the line being written
	always_comb begin
		fill_line = fill_line_q;
		fill_line.word[fill_pos] = i_mem_beat.data;
	end

	always_comb begin
		o_rsp.data = i_mem_beat.data;
		o_rsp.id = req_q.id;
		o_rsp.err = i_mem_beat.err;
		o_rsp_valid = 1'b0;
		o_mem_req = '0;
		o_mem_req_valid = 1'b0;
		o_mem_beat_ready = 1'b0;
		case (state)
			ST_HIT_RSP: begin
				o_rsp_valid = 1'b1;
				o_rsp.data = line_rdata[hit_way_q].word[req_wsel];
				o_rsp.err = 1'b0;
			end
			ST_FILL_REQ: begin
				o_mem_req_valid = 1'b1;
				o_mem_req.addr = {req_q.addr[`L1_ADDR_W-1:2], 2'b00};
				o_mem_req.wrap = 1'b1;
			end
			ST_FILL_FIRST: begin
				o_mem_beat_ready = 1'b1;
				o_rsp_valid = i_mem_beat_valid;
			end
			ST_FILL_STALL: begin
				o_rsp_valid = 1'b1;
				o_rsp = rsp_hold_q;
			end
			ST_FILL_REST: begin
				o_mem_beat_ready = 1'b1;
			end
			ST_UNC_REQ: begin
				o_mem_req_valid = 1'b1;
				o_mem_req.addr = req_q.addr;
				o_mem_req.wrap = 1'b0;
			end
			ST_UNC_DATA: begin
				o_rsp_valid = i_mem_beat_valid;
				o_mem_beat_ready = i_rsp_ready;
			end
			default: begin
				o_rsp_valid = 1'b0;
			end
		endcase
	end

	for (genvar w = 0; w < `L1_WAYS; w++) begin : g_way
		cache_sram #(
			.entry_t(l1_rcache_pkg::line_t),
			.DEPTH(`L1_SETS),
			.ZERO_INIT(1'b0)
		) u_data (
			.clk_i(clk_i),
			.rst_n(rst_n),
			.i_addr(req_q.addr[TAG_LSB-1:IDX_LSB]),
			.i_we(line_wr && i_victim_way == WAY_W'(w)),
			.i_wdata(fill_line),
			.o_rdata(line_rdata[w]),
			.o_busy()
		);
	end

	// Memory side may stall the request, the payload must not move meanwhile
	a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
		o_mem_req_valid && !i_mem_req_ready |=> o_mem_req_valid && $stable(o_mem_req));

endmodule

/* rtl/l1_rcache_top.sv */
`timescale 1ns/100ps
`include "l1_rcache_config.svh"

module l1_rcache_top (
	input  logic                     clk_i,
	input  logic                     rst_n,
	input  l1_rcache_pkg::rd_req_t   i_req,
	input  logic                     i_req_valid,
	output logic                     o_req_ready,
	output l1_rcache_pkg::rd_rsp_t   o_rsp,
	output logic                     o_rsp_valid,
	input  logic                     i_rsp_ready,
	output l1_rcache_pkg::mem_req_t  o_mem_req,
	output logic                     o_mem_req_valid,
	input  logic                     i_mem_req_ready,
	input  l1_rcache_pkg::mem_beat_t i_mem_beat,
	input  logic                     i_mem_beat_valid,
	output logic                     o_mem_beat_ready,
	input  logic [`L1_ADDR_W-1:0]    i_snoop_addr,
	input  logic                     i_snoop_valid,
	output logic                     o_snoop_stall
);
	logic lookup;
	logic [`L1_ADDR_W-1:0] lookup_addr;
	logic hit;
	logic [$clog2(`L1_WAYS)-1:0] hit_way;
	logic [$clog2(`L1_WAYS)-1:0] victim_way;
	logic commit;
	logic [`L1_ADDR_W-1:0] commit_addr;
	logic ctrl_idle;
	logic tag_busy;

	// Snoops wait whenever a request is in flight
	assign o_snoop_stall = !ctrl_idle;

	rcache_ctrl u_ctrl (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_req(i_req),
		.i_req_valid(i_req_valid),
		.o_req_ready(o_req_ready),
		.o_rsp(o_rsp),
		.o_rsp_valid(o_rsp_valid),
		.i_rsp_ready(i_rsp_ready),
		.o_mem_req(o_mem_req),
		.o_mem_req_valid(o_mem_req_valid),
		.i_mem_req_ready(i_mem_req_ready),
		.i_mem_beat(i_mem_beat),
		.i_mem_beat_valid(i_mem_beat_valid),
		.o_mem_beat_ready(o_mem_beat_ready),
		.o_lookup(lookup),
		.o_lookup_addr(lookup_addr),
		.i_hit(hit),
		.i_hit_way(hit_way),
		.i_victim_way(victim_way),
		.o_commit(commit),
		.o_commit_addr(commit_addr),
		.o_idle(ctrl_idle),
		.i_tag_busy(tag_busy)
	);

	tag_lookup u_tags (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_lookup(lookup),
		.i_addr(lookup_addr),
		.i_commit(commit),
		.i_commit_addr(commit_addr),
		.i_snoop_addr(i_snoop_addr),
		.i_snoop_valid(i_snoop_valid),
		.i_idle(ctrl_idle),
		.o_hit(hit),
		.o_hit_way(hit_way),
		.o_victim_way(victim_way),
		.o_busy(tag_busy)
	);

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_i,
	output logic rst_n
);
	initial begin
		clk_i = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_i = ~clk_i;
		end
	end

	// Released on a falling edge like every other input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		@(negedge clk_i);
		rst_n = 1'b1;
	end

endmodule

/* sim/l1_rcache_tb.sv */
`timescale 1ns/100ps
`include "l1_rcache_config.svh"

module l1_rcache_tb;
	localparam int CLK_PERIOD = 40;
	localparam int SAMPLE_DLY = CLK_PERIOD / 4;
	localparam int READY_LIMIT = 400;
	localparam int RSP_LIMIT = 200;
	localparam logic [31:0] SEED = 32'he6b4e016;

	logic clk_i;
	logic rst_n;
	l1_rcache_pkg::rd_req_t i_req;
	logic i_req_valid;
	logic o_req_ready;
	l1_rcache_pkg::rd_rsp_t o_rsp;
	logic o_rsp_valid;
	logic i_rsp_ready;
	l1_rcache_pkg::mem_req_t o_mem_req;
	logic o_mem_req_valid;
	logic i_mem_req_ready;
	l1_rcache_pkg::mem_beat_t i_mem_beat;
	logic i_mem_beat_valid;
	logic o_mem_beat_ready;
	logic [`L1_ADDR_W-1:0] i_snoop_addr;
	logic i_snoop_valid;
	logic o_snoop_stall;

	l1_rcache_pkg::rd_rsp_t exp_rsp_q [$];
	l1_rcache_pkg::rd_req_t cur_req;
	logic [`L1_ID_W-1:0] next_id = '0;
	logic backpressure = 1'b0;
	int value_errs = 0;
	int proto_errs = 0;
	int timeouts = 0;
	int mem_req_count = 0;
	int rsp_count = 0;

	tb_clock_gen #(
		.PERIOD_NS(CLK_PERIOD),
		.RESET_CYCLES(8)
	) u_clk (
		.clk_i(clk_i),
		.rst_n(rst_n)
	);

	l1_rcache_top l1_rcache_top_inst (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Memory contents, a fixed hash of the byte address
	function automatic logic [31:0] mem_word(input logic [`L1_ADDR_W-1:0] addr);
		return xorshift32(xorshift32(addr ^ 32'h9e3779b9) ^ 32'h7f4a7c15);
	endfunction

	// Cacheable reads fetch the aligned word, uncached ones the exact address
	function automatic logic [`L1_ADDR_W-1:0] fetch_addr(input l1_rcache_pkg::rd_req_t r);
		return r.cacheable ? {r.addr[`L1_ADDR_W-1:2], 2'b00} : r.addr;
	endfunction

	function automatic l1_rcache_pkg::rd_rsp_t ref_rsp(input l1_rcache_pkg::rd_req_t r);
		l1_rcache_pkg::rd_rsp_t rsp;
		rsp.data = mem_word(fetch_addr(r));
		rsp.id = r.id;
		rsp.err = 1'b0;
		return rsp;
	endfunction

	function automatic l1_rcache_pkg::mem_req_t ref_mem_req(input l1_rcache_pkg::rd_req_t r);
		l1_rcache_pkg::mem_req_t m;
		m.addr = fetch_addr(r);
		m.wrap = r.cacheable;
		return m;
	endfunction

	task automatic check_rsp(input l1_rcache_pkg::rd_rsp_t exp, input l1_rcache_pkg::rd_rsp_t got);
		if (got !== exp) begin
			value_errs++;
			$display("FAIL o_rsp at %0t: expected data=%h id=%h err=%h, got data=%h id=%h err=%h",
				$time, exp.data, exp.id, exp.err, got.data, got.id, got.err);
		end
	endtask

	task automatic check_mem_req(input l1_rcache_pkg::mem_req_t exp,
		input l1_rcache_pkg::mem_req_t got);
		if (got !== exp) begin
			value_errs++;
			$display("FAIL o_mem_req at %0t: expected addr=%h wrap=%h, got addr=%h wrap=%h",
				$time, exp.addr, exp.wrap, got.addr, got.wrap);
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs, timeouts);
		if (value_errs + proto_errs + timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	task automatic abort_timeout(input string what);
		timeouts++;
		$display("ERROR: timed out at %0t waiting for %s", $time, what);
		finish_run();
	endtask

	// Memory side, random accept delay and random gaps between beats
	initial begin : memory_model
		logic [31:0] rng;
		l1_rcache_pkg::mem_req_t req;
		logic [1:0] pos;
		logic busy;
		logic presenting;
		int beats_left;
		int lat;
		rng = SEED ^ 32'h00ff00ff;
		req = '0;
		pos = '0;
		busy = 1'b0;
		presenting = 1'b0;
		beats_left = 0;
		lat = 0;
		i_mem_req_ready = 1'b0;
		i_mem_beat = '0;
		i_mem_beat_valid = 1'b0;
		forever begin
			@(negedge clk_i);
			rng = xorshift32(rng);
			i_mem_req_ready = !busy && rng[0];
			if (!presenting) begin
				i_mem_beat_valid = 1'b0;
			end
			if (busy && !presenting) begin
				if (lat > 0) begin
					lat--;
				end else begin
					presenting = 1'b1;
					i_mem_beat_valid = 1'b1;
					i_mem_beat.data = mem_word(req.wrap ?
						{req.addr[`L1_ADDR_W-1:4], pos, 2'b00} : req.addr);
					i_mem_beat.err = 1'b0;
					i_mem_beat.last = (beats_left == 1);
				end
			end
			#(SAMPLE_DLY);
			if (rst_n && o_mem_req_valid && i_mem_req_ready) begin
				req = o_mem_req;
				check_mem_req(ref_mem_req(cur_req), req);
				mem_req_count++;
				busy = 1'b1;
				beats_left = req.wrap ? 4 : 1;
				pos = req.addr[3:2];
				lat = int'(rng[3:2]);
			end else if (presenting && o_mem_beat_ready) begin
				presenting = 1'b0;
				pos = pos + 1'b1;
				beats_left--;
				busy = (beats_left > 0);
				lat = int'(rng[5:4]);
			end
		end
	end

	// Requester side, takes responses and compares them in order
	initial begin : response_sink
		logic [31:0] rng;
		int stall_left;
		rng = SEED ^ 32'h0f0f0f0f;
		stall_left = 0;
		i_rsp_ready = 1'b1;
		forever begin
			@(negedge clk_i);
			rng = xorshift32(rng);
			if (backpressure && stall_left > 0) begin
				i_rsp_ready = 1'b0;
				stall_left--;
			end else begin
				i_rsp_ready = 1'b1;
				stall_left = backpressure ? int'(rng[2:0]) : 0;
			end
			#(SAMPLE_DLY);
			if (rst_n && o_rsp_valid && i_rsp_ready) begin
				if (exp_rsp_q.size() == 0) begin
					proto_errs++;
					$display("ERROR: response with id %h arrived with no read outstanding", o_rsp.id);
				end else begin
					check_rsp(exp_rsp_q.pop_front(), o_rsp);
				end
				rsp_count++;
			end
		end
	end

	task automatic send_req(input l1_rcache_pkg::rd_req_t r);
		int cnt;
		cnt = 0;
		@(negedge clk_i);
		i_req = r;
		i_req_valid = 1'b1;
		#(SAMPLE_DLY);
		while (o_req_ready !== 1'b1 && cnt < READY_LIMIT) begin
			@(negedge clk_i);
			#(SAMPLE_DLY);
			cnt++;
		end
		if (o_req_ready === 1'b1) begin
			// Taken on the coming rising edge
			@(negedge clk_i);
			i_req_valid = 1'b0;
		end else begin
			abort_timeout("o_req_ready");
		end
	endtask

	task automatic wait_rsp(input int target);
		int cnt;
		cnt = 0;
		while (rsp_count < target && cnt < RSP_LIMIT) begin
			@(negedge clk_i);
			cnt++;
		end
		if (rsp_count < target) begin
			abort_timeout("o_rsp_valid");
		end
	endtask

	// A negative exp_mem skips the memory request count
	task automatic do_read(input logic [`L1_ADDR_W-1:0] addr, input logic cacheable,
		input int exp_mem);
		l1_rcache_pkg::rd_req_t r;
		int mem_before;
		int target;
		r.addr = addr;
		r.id = next_id;
		r.cacheable = cacheable;
		next_id++;
		cur_req = r;
		exp_rsp_q.push_back(ref_rsp(r));
		mem_before = mem_req_count;
		target = rsp_count + 1;
		send_req(r);
		wait_rsp(target);
		if (exp_mem >= 0 && mem_req_count - mem_before != exp_mem) begin
			proto_errs++;
			$display("ERROR: read of %h made %0d memory requests, expected %0d",
				addr, mem_req_count - mem_before, exp_mem);
		end
	endtask

	task automatic send_snoop(input logic [`L1_ADDR_W-1:0] addr);
		int cnt;
		cnt = 0;
		@(negedge clk_i);
		while ((o_snoop_stall !== 1'b0 || o_req_ready !== 1'b1) && cnt < READY_LIMIT) begin
			@(negedge clk_i);
			cnt++;
		end
		if (o_snoop_stall === 1'b0 && o_req_ready === 1'b1) begin
			i_snoop_addr = addr;
			i_snoop_valid = 1'b1;
			@(negedge clk_i);
			i_snoop_valid = 1'b0;
		end else begin
			abort_timeout("o_snoop_stall to drop");
		end
	endtask

	task automatic run_all_tests();
		logic [31:0] rng;
		logic [`L1_ADDR_W-1:0] base;
		logic [`L1_ADDR_W-1:0] addr;
		logic cacheable;
		int i;
		int cnt;
		rng = SEED;

		// Cold miss in the middle of a line, then every word of it hits
		base = 32'h0000_1230;
		do_read(base + 32'h4, 1'b1, 1);
		for (i = 0; i < 4; i++) begin
			do_read(base + 32'(4 * i), 1'b1, 0);
		end

		// Uncached reads always go out, even to a cached line
		do_read(32'h0004_2006, 1'b0, 1);
		do_read(32'h0004_2006, 1'b0, 1);
		do_read(base + 32'h8, 1'b0, 1);

		// Same set with another tag leaves the line alone
		send_snoop(base + 32'h1000);
		do_read(base + 32'h8, 1'b1, 0);
		send_snoop(base + 32'hc);
		do_read(base + 32'h4, 1'b1, 1);
		do_read(base, 1'b1, 0);

		// Fills under requester stalls, then a reread of each line
		backpressure = 1'b1;
		for (i = 0; i < 8; i++) begin
			rng = xorshift32(rng);
			addr = 32'h0010_0000 + 32'(i * 16) + (rng & 32'hc);
			do_read(addr, 1'b1, 1);
			do_read(addr ^ 32'h4, 1'b1, 0);
		end

		// Mixed traffic over sixteen lines
		for (i = 0; i < 64; i++) begin
			rng = xorshift32(rng);
			addr = 32'h0020_0000 + (rng & 32'hfc);
			cacheable = rng[8];
			backpressure = rng[9];
			do_read(addr, cacheable, cacheable ? -1 : 1);
		end

		cnt = 0;
		@(negedge clk_i);
		while (o_snoop_stall !== 1'b0 && cnt < RSP_LIMIT) begin
			@(negedge clk_i);
			cnt++;
		end
		if (o_snoop_stall !== 1'b0) begin
			abort_timeout("the last fill to finish");
		end else begin
			if (exp_rsp_q.size() != 0) begin
				proto_errs++;
				$display("ERROR: %0d responses never arrived", exp_rsp_q.size());
			end
			finish_run();
		end
	endtask

	initial begin : stimulus
		int cnt;
		i_req = '0;
		i_req_valid = 1'b0;
		i_snoop_addr = '0;
		i_snoop_valid = 1'b0;
		cnt = 0;
		while (rst_n !== 1'b1 && cnt < 20) begin
			@(negedge clk_i);
			cnt++;
		end
		if (rst_n !== 1'b1) begin
			abort_timeout("reset release");
		end else begin
			run_all_tests();
		end
	end

endmodule

/* l1_rcache.f */
+incdir+rtl
rtl/l1_rcache_pkg.sv
rtl/cache_sram.sv
rtl/tag_lookup.sv
rtl/rcache_ctrl.sv
rtl/l1_rcache_top.sv
sim/tb_clock_gen.sv
sim/l1_rcache_tb.sv
